// File: calculator.f
verilog/calcPkg.sv
verilog/signedDivider.sv
verilog/operandDecode.sv
verilog/arithUnit.sv
verilog/decimalSplit.sv
verilog/segmentDriver.sv
verilog/calculator.sv
test/calculator_asserts.sv
test/calculatorTb.sv

// File: run.sh
#!/bin/sh
# Build and run the calculator testbench, exit status carries the result
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f calculator.f --top-module calculatorTb -o calculatorSim \
	&& ./obj_dir/calculatorSim \
	|| exit 1

// File: test/calculatorTb.sv
`timescale 1ns/100ps
`default_nettype none

module calculatorTb;

	import calcPkg::*;

	localparam int Timeout = 50;
	localparam logic [31:0] Seed = 32'hfb4c89ea;
	localparam logic [3:0] ArithOps [4] = '{opAdd, opSub, opMul, opSquare};
	localparam logic [3:0] UnusedOps [9] = '{4'd0, 4'd7, 4'd8, 4'd9, 4'd11, 4'd12, 4'd13,
		4'd14, 4'd15};
	localparam logic [3:0] SignedOps [7] = '{opAdd, opSub, opMul, opDiv, opRem, opFact,
		opSquare};
	localparam logic [4:0] APicks [3] = '{5'd0, 5'd12, 5'd31};
	localparam logic [4:0] BPicks [4] = '{5'd0, 5'd5, 5'd7, 5'd20};

	logic clk;
	logic rstN;
	swWord sw;
	segPattern hex0;
	segPattern hex1;
	segPattern hex2;
	segPattern hex3;
	segPattern hex4;
	segPattern hex5;
	segPattern hex6;
	segPattern hex7;
	logic [31:0] lcgState;

	calculator DUT (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic swWord packSw(input logic enable, input logic [3:0] op,
		input logic signA, input logic [4:0] magA, input logic signB, input logic [4:0] magB);
		return {enable, 1'b0, op, signB, magB, signA, magA};
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic applySw(input swWord value);
		@(posedge clk);
		sw <= value;
	endtask

	// Modes: arith, div and rem, unused codes, enable low, any bits
	task automatic driveRandom(input int count, input int mode);
		logic [3:0] op;
		for (int i = 0; i < count; i++) begin
			lcgState = lcgNext(lcgState);
			if (mode == 4) begin
				applySw(lcgState[31:14]);
			end else begin
				case (mode)
					0: op = ArithOps[lcgState[25:24]];
					1: op = lcgState[24] ? opRem : opDiv;
					2: op = UnusedOps[4'(lcgState[27:24] % 4'd9)];
					default: op = lcgState[27:24];
				endcase
				applySw(packSw(mode != 3, op, lcgState[17], lcgState[16:12],
					lcgState[23], lcgState[22:18]));
			end
		end
	endtask

	// Wait until the last setting has reached the checked stage
	task automatic drainCheck(input string batch);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (DUT.modelCheck.swHist[3] != sw) begin
			if (cycles >= Timeout) begin
				failRun({batch, ": switch settings never reached the display checks"});
			end
			cycles++;
			@(negedge clk);
		end
		@(negedge clk);
		if (DUT.modelCheck.errorCount != 0) begin
			failRun({batch, ": display assertions failed"});
		end
	endtask

	initial begin
		int cycles;
		rstN = 1'b0;
		sw = '0;
		lcgState = Seed;
		repeat (5) @(posedge clk);
		rstN <= 1'b1;

		cycles = 0;
		@(negedge clk);
		while (hex0 == SegBlank) begin
			if (cycles >= Timeout) begin
				failRun("display stayed blank after reset");
			end
			cycles++;
			@(negedge clk);
		end
		drainCheck("reset");

		driveRandom(400, 0);
		drainCheck("add, sub, mul and square");
		driveRandom(200, 1);
		drainCheck("random divide and remainder");

		// All sign pairs, zero magnitudes give negative zeros
		for (int op = 0; op < 7; op++) begin
			for (int signs = 0; signs < 4; signs++) begin
				for (int i = 0; i < 3; i++) begin
					for (int j = 0; j < 4; j++) begin
						applySw(packSw(1'b1, SignedOps[op], signs[1], APicks[i],
							signs[0], BPicks[j]));
					end
				end
			end
		end
		drainCheck("signed directed");

		for (int mag = 0; mag < 32; mag++) begin
			applySw(packSw(1'b1, opFact, mag[0], 5'(mag), 1'b0, 5'(mag)));
		end
		drainCheck("factorial");

		driveRandom(100, 2);
		driveRandom(100, 3);
		drainCheck("unused opcodes and enable low");
		driveRandom(300, 4);
		drainCheck("full random");

		if (DUT.modelCheck.errorCount == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			failRun("assertion errors at end of run");
		end
	end

endmodule

`default_nettype wire

// File: test/calculator_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module calculatorAsserts (
	input logic clk,
	input logic rstN,
	input calcPkg::swWord sw,
	input logic [8*calcPkg::SegWidth-1:0] display
);

	import calcPkg::*;

	int errorCount;
	swWord swHist [4];
	logic [3:0] upHist;
	logic [8*SegWidth-1:0] expected;

	// Board style 7 carries the segment f tail
	function automatic segPattern segOf(input int digit);
		case (digit)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1011000;
			8: return 7'b0000000;
			9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	// Expected hex7 down to hex0 for one switch setting
	function automatic logic [8*SegWidth-1:0] modelDisplay(input swWord s);
		int magA;
		int magB;
		int a;
		int b;
		int value;
		int shown;
		magA = int'(s[4:0]);
		magB = int'(s[10:6]);
		a = s[5] ? -magA : magA;
		b = s[11] ? -magB : magB;
		case (int'(s[15:12]))
			1: value = a + b;
			2: value = a - b;
			3: value = a * b;
			4: value = (b == 0) ? 0 : (a * DecScale) / b;
			5: value = (b == 0) ? 0 : a % b;
			6: begin
				value = 1;
				for (int k = 2; k <= magA; k++) begin
					value = value * k;
				end
				if (magA >= FactLimit) begin
					value = 0;
				end
			end
			10: value = a * a;
			default: value = 0;
		endcase
		if (!s[17]) begin
			value = 0;
		end
		// Datapath wraps at 15 bits
		value = int'(calcValue'(value));
		shown = ((value < 0) ? -value : value) % 1000;
		return {segOf(magA / 10), segOf(magA % 10), segOf(magB / 10), segOf(magB % 10),
			(value < 0) ? 7'b0111111 : 7'b1111111,
			segOf(shown / 100), segOf(shown / 10 % 10), segOf(shown % 10)};
	endfunction

	// Reset fills the history with the all-zero setting
	always_ff @(posedge clk) begin
		if (!rstN) begin
			swHist <= '{default: '0};
			upHist <= '0;
		end else begin
			swHist <= '{sw, swHist[0], swHist[1], swHist[2]};
			upHist <= {upHist[2:0], 1'b1};
		end
	end

	assign expected = modelDisplay(swHist[3]);

	// Four cycles of blank display while the stages fill after release
	fillBlank: assert property (@(posedge clk) (rstN && !upHist[3]) |-> (display == '1))
		else begin
			$error("error %0t: display %h not blank while the pipeline fills", $time,
				display);
			errorCount = errorCount + 1;
		end

	resultShown: assert property (@(posedge clk) (rstN && upHist[3])
		|-> (display[4*SegWidth-1:0] == expected[4*SegWidth-1:0]))
		else begin
			$error("error %0t: result digits %h, expected %h", $time,
				display[4*SegWidth-1:0], expected[4*SegWidth-1:0]);
			errorCount = errorCount + 1;
		end

	operandsShown: assert property (@(posedge clk) (rstN && upHist[3])
		|-> (display[8*SegWidth-1:4*SegWidth] == expected[8*SegWidth-1:4*SegWidth]))
		else begin
			$error("error %0t: operand digits %h, expected %h", $time,
				display[8*SegWidth-1:4*SegWidth], expected[8*SegWidth-1:4*SegWidth]);
			errorCount = errorCount + 1;
		end

endmodule

bind calculator calculatorAsserts modelCheck (
	.clk    (clk),
	.rstN   (rstN),
	.sw     (sw),
	.display({hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0})
);

`default_nettype wire

// File: verilog/arithUnit.sv
`timescale 1ns/100ps
`default_nettype none

module arithUnit (
	input  logic clk,
	input  logic rstN,
	input  calcPkg::operandPair operands,
	output calcPkg::resultWord result
);

	import calcPkg::*;

	calcValue sum;
	calcValue difference;
	calcValue product;
	calcValue square;
	calcValue factorial;
	calcValue scaledA;
	calcValue scaledQuotient;
	calcValue remainder;
	calcValue nextValue;

	assign sum = operands.a + operands.b;
	assign difference = operands.a - operands.b;

	// Products keep only the low ValueWidth bits
	assign product = operands.a * operands.b;
	assign square = operands.a * operands.a;

	assign scaledA = calcValue'(operands.a * DecScale);

	always_comb begin
		if (operands.magA >= opMag'(FactLimit)) begin
			factorial = '0;
		end else begin
			factorial = FactTable[operands.magA[$clog2(FactLimit)-1:0]];
		end
	end

	signedDivider scaledDiv (
		.dividend (scaledA),
		.divisor  (operands.b),
		.quotient (scaledQuotient),
		.remainder()
	);

	signedDivider remDiv (
		.dividend (operands.a),
		.divisor  (operands.b),
		.quotient (),
		.remainder(remainder)
	);

	always_comb begin
		case (operands.op)
			opNone:   nextValue = '0;
			opAdd:    nextValue = sum;
			opSub:    nextValue = difference;
			opMul:    nextValue = product;
			opDiv:    nextValue = scaledQuotient;
			opRem:    nextValue = remainder;
			opFact:   nextValue = factorial;
			opSquare: nextValue = square;
			// Unused codes
			default:  nextValue = '0;
		endcase
		if (!operands.enable) begin
			nextValue = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			result <= '0;
		end else begin
			result.result <= nextValue;
			result.magA <= operands.magA;
			result.magB <= operands.magB;
		end
	end

endmodule

`default_nettype wire

// File: verilog/calcPkg.sv
`default_nettype none

package calcPkg;

	localparam int SwWidth = 18;
	localparam int MagWidth = 5;
	localparam int ValueWidth = 15;
	localparam int SegWidth = 7;

	// Division result is scaled to two decimal places
	localparam int DecScale = 100;
	localparam int FactLimit = 8;

	typedef logic [SwWidth-1:0] swWord;
	typedef logic signed [ValueWidth-1:0] calcValue;
	typedef logic [MagWidth-1:0] opMag;
	typedef logic [3:0] bcdDigit;

	// Active low, bit 0 is segment a
	typedef logic [SegWidth-1:0] segPattern;

	localparam segPattern SegBlank = 7'b1111111;
	localparam segPattern SegMinus = 7'b0111111;

	// Digits 0 to 9, gfedcba order
	localparam segPattern DigitSegs [10] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
		7'b0010010, 7'b0000010, 7'b1011000, 7'b0000000, 7'b0010000
	};

	localparam calcValue FactTable [FactLimit] = '{
		15'd1, 15'd1, 15'd2, 15'd6, 15'd24, 15'd120, 15'd720, 15'd5040
	};

	typedef enum logic [3:0] {
		opNone   = 4'd0,
		opAdd    = 4'd1,
		opSub    = 4'd2,
		opMul    = 4'd3,
		opDiv    = 4'd4,
		opRem    = 4'd5,
		opFact   = 4'd6,
		opSquare = 4'd10
	} calcOp;

	typedef struct packed {
		calcValue a;
		calcValue b;
		opMag magA;
		opMag magB;
		calcOp op;
		logic enable;
	} operandPair;

	typedef struct packed {
		calcValue result;
		opMag magA;
		opMag magB;
	} resultWord;

	typedef struct packed {
		bcdDigit resHunds;
		bcdDigit resTens;
		bcdDigit resOnes;
		logic negative;
		bcdDigit bTens;
		bcdDigit bOnes;
		bcdDigit aTens;
		bcdDigit aOnes;
	} digitSet;

endpackage

`default_nettype wire

// File: verilog/calculator.sv
`timescale 1ns/100ps
`default_nettype none

module calculator (
	input  logic clk,
	input  logic rstN,
	input  calcPkg::swWord sw,
	output calcPkg::segPattern hex0,
	output calcPkg::segPattern hex1,
	output calcPkg::segPattern hex2,
	output calcPkg::segPattern hex3,
	output calcPkg::segPattern hex4,
	output calcPkg::segPattern hex5,
	output calcPkg::segPattern hex6,
	output calcPkg::segPattern hex7
);

	import calcPkg::*;

	operandPair operands;
	resultWord result;
	digitSet digits;

	operandDecode decodeStage (
		.clk     (clk),
		.rstN    (rstN),
		.sw      (sw),
		.operands(operands)
	);

	arithUnit arithStage (
		.clk     (clk),
		.rstN    (rstN),
		.operands(operands),
		.result  (result)
	);

	decimalSplit splitStage (
		.clk   (clk),
		.rstN  (rstN),
		.result(result),
		.digits(digits)
	);

	segmentDriver driveStage (
		.clk   (clk),
		.rstN  (rstN),
		.digits(digits),
		.hex0  (hex0),
		.hex1  (hex1),
		.hex2  (hex2),
		.hex3  (hex3),
		.hex4  (hex4),
		.hex5  (hex5),
		.hex6  (hex6),
		.hex7  (hex7)
	);

endmodule

`default_nettype wire

// File: verilog/decimalSplit.sv
`timescale 1ns/100ps
`default_nettype none

module decimalSplit (
	input  logic clk,
	input  logic rstN,
	input  calcPkg::resultWord result,
	output calcPkg::digitSet digits
);

	import calcPkg::*;

	logic [ValueWidth-1:0] magnitude;
	logic [9:0] reduced;
	logic negative;

	assign negative = result.result[ValueWidth-1];
	assign magnitude = negative ? -result.result : result.result;

	// Only three result digits on the board
	assign reduced = 10'(magnitude % 1000);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			digits <= '0;
		end else begin
			digits.resHunds <= bcdDigit'(reduced / 100);
			digits.resTens <= bcdDigit'((reduced / 10) % 10);
			digits.resOnes <= bcdDigit'(reduced % 10);
			digits.negative <= negative;
			digits.bTens <= bcdDigit'(result.magB / 10);
			digits.bOnes <= bcdDigit'(result.magB % 10);
			digits.aTens <= bcdDigit'(result.magA / 10);
			digits.aOnes <= bcdDigit'(result.magA % 10);
		end
	end

endmodule

`default_nettype wire

// File: verilog/operandDecode.sv
`timescale 1ns/100ps
`default_nettype none

module operandDecode (
	input  logic clk,
	input  logic rstN,
	input  calcPkg::swWord sw,
	output calcPkg::operandPair operands
);

	import calcPkg::*;

	opMag magA;
	opMag magB;
	logic signA;
	logic signB;

	// Sign-magnitude to two's complement, minus zero folds to 0
	function automatic calcValue toSigned(input logic negative, input opMag mag);
		calcValue extended;
		extended = calcValue'(mag);
		return negative ? -extended : extended;
	endfunction

	assign magA = sw[4:0];
	assign signA = sw[5];
	assign magB = sw[10:6];
	assign signB = sw[11];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			operands <= '0;
		end else begin
			operands.a <= toSigned(signA, magA);
			operands.b <= toSigned(signB, magB);
			operands.magA <= magA;
			operands.magB <= magB;
			operands.op <= calcOp'(sw[15:12]);
			operands.enable <= sw[17];
		end
	end

endmodule

`default_nettype wire

// File: verilog/segmentDriver.sv
`timescale 1ns/100ps
`default_nettype none

module segmentDriver (
	input  logic clk,
	input  logic rstN,
	input  calcPkg::digitSet digits,
	output calcPkg::segPattern hex0,
	output calcPkg::segPattern hex1,
	output calcPkg::segPattern hex2,
	output calcPkg::segPattern hex3,
	output calcPkg::segPattern hex4,
	output calcPkg::segPattern hex5,
	output calcPkg::segPattern hex6,
	output calcPkg::segPattern hex7
);

	import calcPkg::*;

	logic [2:0] validPipe;

	// Codes above 9 stay dark
	function automatic segPattern encodeDigit(input bcdDigit code);
		return (code <= 4'd9) ? DigitSegs[code] : SegBlank;
	endfunction

	// Upstream stages hold reset zeros for three edges after release
	always_ff @(posedge clk) begin
		if (!rstN) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[1:0], 1'b1};
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN || !validPipe[2]) begin
			hex0 <= SegBlank;
			hex1 <= SegBlank;
			hex2 <= SegBlank;
			hex3 <= SegBlank;
			hex4 <= SegBlank;
			hex5 <= SegBlank;
			hex6 <= SegBlank;
			hex7 <= SegBlank;
		end else begin
			hex0 <= encodeDigit(digits.resOnes);
			hex1 <= encodeDigit(digits.resTens);
			hex2 <= encodeDigit(digits.resHunds);
			hex3 <= digits.negative ? SegMinus : SegBlank;
			hex4 <= encodeDigit(digits.bOnes);
			hex5 <= encodeDigit(digits.bTens);
			hex6 <= encodeDigit(digits.aOnes);
			hex7 <= encodeDigit(digits.aTens);
		end
	end

endmodule

`default_nettype wire

// File: verilog/signedDivider.sv
`timescale 1ns/100ps
`default_nettype none

module signedDivider (
	input  calcPkg::calcValue dividend,
	input  calcPkg::calcValue divisor,
	output calcPkg::calcValue quotient,
	output calcPkg::calcValue remainder
);

	import calcPkg::*;

	logic [ValueWidth-1:0] absDividend;
	logic [ValueWidth-1:0] absDivisor;
	logic [ValueWidth:0] remWork;
	logic [ValueWidth-1:0] quoWork;
	logic negQuot;
	logic negRem;

	assign absDividend = dividend[ValueWidth-1] ? -dividend : dividend;
	assign absDivisor = divisor[ValueWidth-1] ? -divisor : divisor;
	assign negQuot = dividend[ValueWidth-1] ^ divisor[ValueWidth-1];
	assign negRem = dividend[ValueWidth-1];

	// Restoring division, one quotient bit per step from the top
	always_comb begin
		remWork = '0;
		quoWork = '0;
		for (int i = ValueWidth - 1; i >= 0; i--) begin
			remWork = {remWork[ValueWidth-1:0], absDividend[i]};
			if (remWork >= {1'b0, absDivisor}) begin
				remWork = remWork - {1'b0, absDivisor};
				quoWork[i] = 1'b1;
			end
		end
	end

	always_comb begin
		if (absDivisor == '0) begin
			quotient = '0;
			remainder = '0;
		end else begin
			// Truncate toward zero, remainder follows the dividend
			quotient = negQuot ? -calcValue'(quoWork) : calcValue'(quoWork);
			remainder = negRem ? -calcValue'(remWork[ValueWidth-1:0])
				: calcValue'(remWork[ValueWidth-1:0]);
		end
	end

endmodule

`default_nettype wire
